/* Makefile */
VERILATOR ?= verilator
TOP       ?= clock_tb
FILELIST  ?= verilog.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)

/* bench/clock_assert.sv */
`timescale 1ns/1ps

`include "clock_params.svh"

module clock_assert (
  input logic                   clk,
  input logic                   rst_n,
  input logic [`NUM_DIGITS-1:0] i_seg_enb,
  input logic                   i_alarm,
  input logic                   i_alarm_en,
  input clock_pkg::hms_t        i_now,
  input clock_pkg::hms_t        i_alarm_time
);

  // One digit lit at a time
  assert property (@(posedge clk) disable iff (!rst_n) $onehot(~i_seg_enb))
    else $error("o_seg_enb does not enable exactly one digit");

  assert property (@(posedge clk) disable iff (!rst_n) !i_alarm_en |=> !i_alarm)
    else $error("o_alarm high after alarm enable was low");

  // --------------------------------------------------
  // Field ranges
  // --------------------------------------------------
  assert property (@(posedge clk) disable iff (!rst_n)
    i_now.sec <= `SEC_MAX && i_now.min <= `MIN_MAX && i_now.hour <= `HOUR_MAX)
    else $error("current time field out of range");

  assert property (@(posedge clk) disable iff (!rst_n)
    i_alarm_time.sec <= `SEC_MAX && i_alarm_time.min <= `MIN_MAX &&
    i_alarm_time.hour <= `HOUR_MAX)
    else $error("alarm time field out of range");

endmodule

bind clock_top clock_assert clock_assert_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .i_seg_enb    (o_seg_enb),
  .i_alarm      (o_alarm),
  .i_alarm_en   (alarm_en),
  .i_now        (now),
  .i_alarm_time (alarm_time)
);

/* bench/clock_patterns.txt */
# P <button> <presses> | W <seconds> | A <o_alarm>
# D <digits hhmmss> <dp mask, hours tens first>
D 000000 000000  A 0
# first read already spans one second tick
W 60  P mode 1  D 000101 000011  A 0
P pos 2  P inc 23  D 230101 110000
P pos 2  P inc 58  D 235901 001100
P pos 2  P inc 58  D 235959 000011
# time frozen in setup
W 2  D 235959 000011
P inc 1  D 235900 000011  P inc 59
P pos 1  P inc 1  D 230059 001100  P inc 59  P pos 2
# leave setup and freeze again one second later
W 1  P mode 2  W 1  P mode 1  D 000000 000011
# alarm mode, time runs one second per line
W 1  P mode 1  P inc 1
W 1  P inc 2
W 1  P inc 2
W 1  P mode 1  P alarm 1  A 0
W 1  A 0
W 1  A 1
W 2  A 1  P alarm 1  A 0  W 1  A 0
P mode 2  D 000005 000011

/* bench/clock_tb.sv */
`timescale 1ns/1ps

`include "clock_params.svh"

module clock_tb;

  logic                   clk = 1'b0;
  logic                   rst_n;
  clock_pkg::btn_t        btn;
  logic [`SEG_W-1:0]      seg;
  logic [`NUM_DIGITS-1:0] seg_enb;
  logic                   seg_dp;
  logic                   alarm;
  int unsigned            edge_cnt;  // Posedges since reset release

  clock_top clock_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_btn     (btn),
    .o_seg     (seg),
    .o_seg_enb (seg_enb),
    .o_seg_dp  (seg_dp),
    .o_alarm   (alarm)
  );

  always #4 clk = ~clk;

  // Second ticks land on every CLK_TICKS_PER_SEC-th edge after reset
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      edge_cnt <= 0;
    else
      edge_cnt <= edge_cnt + 1;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
      abort_run("Mismatch on a checked value");
    end
  endtask

  // Segment pattern back to a number with bit 6 as segment a
  function automatic int seg_to_num(input logic [`SEG_W-1:0] s);
    case (s)
      7'b111_1110: return 0;
      7'b011_0000: return 1;
      7'b110_1101: return 2;
      7'b111_1001: return 3;
      7'b011_0011: return 4;
      7'b101_1011: return 5;
      7'b101_1111: return 6;
      7'b111_0000: return 7;
      7'b111_1111: return 8;
      7'b111_0011: return 9;
      default:     return -1;
    endcase
  endfunction

  task automatic press_button(input logic [63:0] name, input int count);
    int unsigned hold;
    for (int i = 0; i < count; i++) begin
      hold = 1 + ($urandom % 5);
      case (name)
        "mode":  btn.mode  = 1'b1;
        "pos":   btn.pos   = 1'b1;
        "inc":   btn.inc   = 1'b1;
        "alarm": btn.alarm = 1'b1;
        default: abort_run("Unknown button name in pattern file");
      endcase
      repeat (hold) @(negedge clk);
      btn = '0;
      repeat (4) @(negedge clk);  // Action has landed by now
    end
  endtask

  task automatic wait_seconds(input int n);
    int ticks;
    int guard;
    ticks = 0;
    guard = 0;
    while (ticks < n) begin
      @(negedge clk);
      guard++;
      if (edge_cnt % `CLK_TICKS_PER_SEC == 0)
        ticks++;
      if (guard > (n + 1) * `CLK_TICKS_PER_SEC)
        abort_run("Timeout: the wait for second ticks overran");
    end
    @(negedge clk);  // o_alarm follows one cycle later
  endtask

  task automatic read_display(output logic [`NUM_DIGITS-1:0][3:0] digs,
                              output logic [`NUM_DIGITS-1:0] dps);
    int guard;
    int num;
    for (int k = 0; k < `NUM_DIGITS; k++) begin
      guard = 0;
      while (seg_enb[k] !== 1'b0) begin
        @(negedge clk);
        guard++;
        if (guard > 2 * `SCAN_TICKS_PER_DIGIT * `NUM_DIGITS)
          abort_run($sformatf("Timeout: digit %0d was never enabled", k));
      end
      num = seg_to_num(seg);
      if (num < 0)
        abort_run($sformatf("Unknown segment pattern %b on digit %0d", seg, k));
      digs[k] = 4'(num);
      dps[k]  = seg_dp;
    end
  endtask

  // --------------------------------------------------
  // Pattern file interpreter
  // --------------------------------------------------
  initial begin
    logic [63:0]                   cmd;
    logic [63:0]                   arg;
    logic [63:0]                   dstr;
    logic [63:0]                   pstr;
    logic [8*128-1:0]              line;
    logic [`NUM_DIGITS-1:0][3:0]   digs;
    logic [`NUM_DIGITS-1:0]        dps;
    int                            fd;
    int                            num;
    int                            cnt;
    int unsigned                   seed;
    seed  = $urandom(32'h4378_7436);
    rst_n = 1'b0;
    btn   = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    fd = $fopen("bench/clock_patterns.txt", "r");
    if (fd == 0)
      abort_run("Cannot open bench/clock_patterns.txt");
    while ($fscanf(fd, "%s", cmd) == 1) begin
      case (cmd)
        "#": cnt = $fgets(line, fd);  // Rest of line is a comment
        "P": begin
          cnt = $fscanf(fd, "%s %d", arg, num);
          if (cnt != 2)
            abort_run("Malformed press command in pattern file");
          press_button(arg, num);
        end
        "W": begin
          cnt = $fscanf(fd, "%d", num);
          if (cnt != 1)
            abort_run("Malformed wait command in pattern file");
          wait_seconds(num);
        end
        "D": begin
          cnt = $fscanf(fd, "%s %s", dstr, pstr);
          if (cnt != 2)
            abort_run("Malformed display command in pattern file");
          read_display(digs, dps);
          for (int k = 0; k < `NUM_DIGITS; k++) begin
            check_value($sformatf("digit %0d", k), 32'(digs[k]),
                        int'(dstr[8*k +: 8] - "0"));
            check_value($sformatf("o_seg_dp digit %0d", k), 32'(dps[k]),
                        int'(pstr[8*k +: 8] == "1"));
          end
        end
        "A": begin
          cnt = $fscanf(fd, "%d", num);
          if (cnt != 1)
            abort_run("Malformed alarm command in pattern file");
          check_value("o_alarm", 32'(alarm), num);
        end
        default: abort_run("Unknown command in pattern file");
      endcase
    end
    $fclose(fd);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* hdl/alarm_set.sv */
`timescale 1ns/1ps

module alarm_set (
  input  logic             clk,
  input  logic             rst_n,
  input  clock_pkg::mode_t i_mode,
  input  clock_pkg::pos_t  i_pos,
  input  logic             i_inc,
  input  logic             i_alarm_en,
  input  clock_pkg::hms_t  i_now,
  output clock_pkg::hms_t  o_alarm_time,
  output logic             o_alarm
);

  logic hit;

  // --------------------------------------------------
  // Alarm time registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_alarm_time <= '0;
    end else if (i_mode == clock_pkg::MODE_ALARM && i_inc) begin
      o_alarm_time <= clock_pkg::inc_field(o_alarm_time, i_pos);
    end
  end

  assign hit = (i_now == o_alarm_time);

  // Sticky until disabled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_alarm <= 1'b0;
    end else begin
      o_alarm <= i_alarm_en & (o_alarm | hit);
    end
  end

endmodule

/* hdl/clock_params.svh */
`ifndef CLOCK_PARAMS_SVH
`define CLOCK_PARAMS_SVH

// --------------------------------------------------
// Timing scaled down for simulation
// --------------------------------------------------
`define CLK_TICKS_PER_SEC    32'd20
`define SCAN_TICKS_PER_DIGIT 4

// --------------------------------------------------
// Field limits
// --------------------------------------------------
`define SEC_MAX  6'd59
`define MIN_MAX  6'd59
`define HOUR_MAX 6'd23

// Display geometry
`define NUM_DIGITS 6
`define SEG_W      7  // Segments a..g

`endif

/* hdl/clock_pkg.sv */
`include "clock_params.svh"

package clock_pkg;

  typedef struct packed {
    logic [5:0] hour;
    logic [5:0] min;
    logic [5:0] sec;
  } hms_t;

  typedef enum logic [1:0] {MODE_CLOCK, MODE_SETUP, MODE_ALARM} mode_t;

  typedef enum logic [1:0] {POS_SEC, POS_MIN, POS_HOUR} pos_t;

  // One-cycle press pulses
  typedef struct packed {
    logic mode;
    logic pos;
    logic inc;
    logic alarm;
  } btn_t;

  // Step one field with wrap at its top and no carry
  function automatic hms_t inc_field(hms_t t, pos_t p);
    hms_t r;
    r = t;
    case (p)
      POS_SEC:  r.sec  = (t.sec == `SEC_MAX) ? 6'd0 : t.sec + 6'd1;
      POS_MIN:  r.min  = (t.min == `MIN_MAX) ? 6'd0 : t.min + 6'd1;
      POS_HOUR: r.hour = (t.hour == `HOUR_MAX) ? 6'd0 : t.hour + 6'd1;
      default:  r = t;
    endcase
    return r;
  endfunction

endpackage

/* hdl/clock_top.sv */
`timescale 1ns/1ps

`include "clock_params.svh"

module clock_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  clock_pkg::btn_t        i_btn,
  output logic [`SEG_W-1:0]      o_seg,
  output logic [`NUM_DIGITS-1:0] o_seg_enb,
  output logic                   o_seg_dp,
  output logic                   o_alarm
);

  clock_pkg::mode_t mode;
  clock_pkg::pos_t  pos;
  logic             alarm_en;
  logic             inc;
  clock_pkg::hms_t  now;
  clock_pkg::hms_t  alarm_time;

  // --------------------------------------------------
  // Buttons and mode state
  // --------------------------------------------------
  mode_ctrl mode_ctrl_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_btn      (i_btn),
    .o_mode     (mode),
    .o_pos      (pos),
    .o_alarm_en (alarm_en),
    .o_inc      (inc)
  );

  time_keeper time_keeper_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_mode (mode),
    .i_pos  (pos),
    .i_inc  (inc),
    .o_now  (now)
  );

  alarm_set alarm_set_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mode       (mode),
    .i_pos        (pos),
    .i_inc        (inc),
    .i_alarm_en   (alarm_en),
    .i_now        (now),
    .o_alarm_time (alarm_time),
    .o_alarm      (o_alarm)
  );

  // Seven-segment output
  display_scan display_scan_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mode       (mode),
    .i_pos        (pos),
    .i_now        (now),
    .i_alarm_time (alarm_time),
    .o_seg        (o_seg),
    .o_seg_enb    (o_seg_enb),
    .o_seg_dp     (o_seg_dp)
  );

endmodule

/* hdl/display_scan.sv */
`timescale 1ns/1ps

`include "clock_params.svh"

module display_scan (
  input  logic                   clk,
  input  logic                   rst_n,
  input  clock_pkg::mode_t       i_mode,
  input  clock_pkg::pos_t        i_pos,
  input  clock_pkg::hms_t        i_now,
  input  clock_pkg::hms_t        i_alarm_time,
  output logic [`SEG_W-1:0]      o_seg,
  output logic [`NUM_DIGITS-1:0] o_seg_enb,  // Active low
  output logic                   o_seg_dp
);

  logic [15:0]                  scan_cnt;
  logic [2:0]                   digit_idx;
  clock_pkg::hms_t              shown;
  logic [`NUM_DIGITS-1:0][3:0]  digits;
  logic [`NUM_DIGITS-1:0]       dp_mask;

  // Bit 6 is segment a
  function automatic logic [`SEG_W-1:0] seg_decode(input logic [3:0] num);
    case (num)
      4'd0:    seg_decode = 7'b111_1110;
      4'd1:    seg_decode = 7'b011_0000;
      4'd2:    seg_decode = 7'b110_1101;
      4'd3:    seg_decode = 7'b111_1001;
      4'd4:    seg_decode = 7'b011_0011;
      4'd5:    seg_decode = 7'b101_1011;
      4'd6:    seg_decode = 7'b101_1111;
      4'd7:    seg_decode = 7'b111_0000;
      4'd8:    seg_decode = 7'b111_1111;
      4'd9:    seg_decode = 7'b111_0011;
      default: seg_decode = 7'b000_0000;
    endcase
  endfunction

  // --------------------------------------------------
  // Digit scan counter
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scan_cnt  <= '0;
      digit_idx <= '0;
    end else if (scan_cnt == 16'(`SCAN_TICKS_PER_DIGIT - 1)) begin
      scan_cnt  <= '0;
      digit_idx <= (digit_idx == 3'(`NUM_DIGITS - 1)) ? 3'd0 : digit_idx + 3'd1;
    end else begin
      scan_cnt <= scan_cnt + 16'd1;
    end
  end

  // Digit 0 is seconds ones
  always_comb begin
    shown     = (i_mode == clock_pkg::MODE_ALARM) ? i_alarm_time : i_now;
    digits[0] = 4'(shown.sec % 6'd10);
    digits[1] = 4'(shown.sec / 6'd10);
    digits[2] = 4'(shown.min % 6'd10);
    digits[3] = 4'(shown.min / 6'd10);
    digits[4] = 4'(shown.hour % 6'd10);
    digits[5] = 4'(shown.hour / 6'd10);
  end

  // Decimal points mark the field being edited
  always_comb begin
    dp_mask = '0;
    if (i_mode != clock_pkg::MODE_CLOCK) begin
      case (i_pos)
        clock_pkg::POS_SEC:  dp_mask[1:0] = 2'b11;
        clock_pkg::POS_MIN:  dp_mask[3:2] = 2'b11;
        clock_pkg::POS_HOUR: dp_mask[5:4] = 2'b11;
        default:             dp_mask      = '0;
      endcase
    end
  end

  assign o_seg     = seg_decode(digits[digit_idx]);
  assign o_seg_enb = ~(`NUM_DIGITS'(1) << digit_idx);
  assign o_seg_dp  = dp_mask[digit_idx];

endmodule

/* hdl/mode_ctrl.sv */
`timescale 1ns/1ps

module mode_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  clock_pkg::btn_t  i_btn,
  output clock_pkg::mode_t o_mode,
  output clock_pkg::pos_t  o_pos,
  output logic             o_alarm_en,
  output logic             o_inc
);

  clock_pkg::btn_t btn_meta;
  clock_pkg::btn_t btn_sync;
  clock_pkg::btn_t btn_prev;  // For rising edge detect
  clock_pkg::btn_t press;

  // --------------------------------------------------
  // Synchronizer and edge pulse
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      btn_meta <= '0;
      btn_sync <= '0;
      btn_prev <= '0;
      press    <= '0;
    end else begin
      btn_meta <= i_btn;
      btn_sync <= btn_meta;
      btn_prev <= btn_sync;
      press    <= btn_sync & ~btn_prev;  // One pulse per press
    end
  end

  // --------------------------------------------------
  // Mode, position, alarm enable
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_mode     <= clock_pkg::MODE_CLOCK;
      o_pos      <= clock_pkg::POS_SEC;
      o_alarm_en <= 1'b0;
    end else begin
      if (press.mode) begin
        case (o_mode)
          clock_pkg::MODE_CLOCK: o_mode <= clock_pkg::MODE_SETUP;
          clock_pkg::MODE_SETUP: o_mode <= clock_pkg::MODE_ALARM;
          default:               o_mode <= clock_pkg::MODE_CLOCK;
        endcase
      end
      if (press.pos) begin
        case (o_pos)
          clock_pkg::POS_SEC: o_pos <= clock_pkg::POS_MIN;
          clock_pkg::POS_MIN: o_pos <= clock_pkg::POS_HOUR;
          default:            o_pos <= clock_pkg::POS_SEC;
        endcase
      end
      if (press.alarm)
        o_alarm_en <= ~o_alarm_en;
    end
  end

  assign o_inc = press.inc;

endmodule

/* hdl/time_keeper.sv */
`timescale 1ns/1ps

`include "clock_params.svh"

module time_keeper (
  input  logic             clk,
  input  logic             rst_n,
  input  clock_pkg::mode_t i_mode,
  input  clock_pkg::pos_t  i_pos,
  input  logic             i_inc,
  output clock_pkg::hms_t  o_now
);

  logic [31:0] tick_cnt;
  logic        sec_tick;

  // --------------------------------------------------
  // One second tick
  // --------------------------------------------------
  assign sec_tick = (tick_cnt == `CLK_TICKS_PER_SEC - 32'd1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tick_cnt <= '0;
    end else if (sec_tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 32'd1;
    end
  end

  // --------------------------------------------------
  // Hour, minute, second chain
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_now <= '0;
    end else if (i_mode == clock_pkg::MODE_SETUP) begin
      // Time frozen while inc edits one field
      if (i_inc)
        o_now <= clock_pkg::inc_field(o_now, i_pos);
    end else if (sec_tick) begin
      if (o_now.sec == `SEC_MAX) begin
        o_now.sec <= 6'd0;
        if (o_now.min == `MIN_MAX) begin
          o_now.min <= 6'd0;
          if (o_now.hour == `HOUR_MAX)
            o_now.hour <= 6'd0;  // Midnight wrap
          else
            o_now.hour <= o_now.hour + 6'd1;
        end else begin
          o_now.min <= o_now.min + 6'd1;
        end
      end else begin
        o_now.sec <= o_now.sec + 6'd1;
      end
    end
  end

endmodule

/* verilog.f */
+incdir+hdl
hdl/clock_pkg.sv
hdl/mode_ctrl.sv
hdl/time_keeper.sv
hdl/alarm_set.sv
hdl/display_scan.sv
hdl/clock_top.sv
bench/clock_assert.sv
bench/clock_tb.sv
